// File: dv/ifu_checker.sv
////////////////////////////////////////////////////////////////////////////
// scoreboard on the top-level ports: mirrors memory writes, predicts the
// fetched pc sequence and its words, and counts mismatches
////////////////////////////////////////////////////////////////////////////

module ifu_checker #(
    parameter ifu_pkg::addr_t RESET_PC  = 32'h0,
    parameter int             MEM_WORDS = 64
) (
    input logic                 clk,
    input logic                 rst,
    input logic                 run,
    input logic                 redirect_valid,
    input ifu_pkg::addr_t       redirect_pc,
    input logic                 inst_ready,
    input ifu_pkg::axi_wr_req_t wr_req,
    input ifu_pkg::fetch_out_t  fetch_out,
    input ifu_pkg::axi_wr_rsp_t wr_rsp
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam ifu_pkg::addr_t MEM_BYTES = MEM_WORDS * 4;

    logic [31:0]        model [MEM_WORDS];
    ifu_pkg::axi_resp_e bresp_q [$];
    ifu_pkg::axi_resp_e exp_resp;
    logic               exp_wr_ready;
    ifu_pkg::addr_t     exp_pc;
    logic               consumed;
    int                 run_low_items;
    int                 items_consumed = 0;
    int                 fetch_errors = 0;
    int                 write_errors = 0;
    int                 gating_errors = 0;

    function automatic ifu_pkg::inst_t expected_inst(input ifu_pkg::addr_t pc);
        if (pc < MEM_BYTES) begin
            return model[pc >> 2];
        end
        return '0;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            exp_pc = RESET_PC;
            run_low_items = 0;
            bresp_q.delete();
        end else begin
            // both readies rise with both beats present and no response pending
            exp_wr_ready = wr_req.awvalid && wr_req.wvalid && (bresp_q.size() == 0);
            if (wr_rsp.awready !== exp_wr_ready || wr_rsp.wready !== exp_wr_ready) begin
                write_errors++;
                $display("Fail %0d ns: awready %b wready %b, expected %b",
                         $time, wr_rsp.awready, wr_rsp.wready, exp_wr_ready);
            end

            // accepted write, out-of-range ones leave the model alone
            if (wr_rsp.awready) begin
                if (wr_req.awaddr < MEM_BYTES) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wr_req.wstrb[b]) begin
                            model[wr_req.awaddr >> 2][8*b +: 8] = wr_req.wdata[8*b +: 8];
                        end
                    end
                    bresp_q.push_back(ifu_pkg::OKAY);
                end else begin
                    bresp_q.push_back(ifu_pkg::SLVERR);
                end
            end
            if (wr_rsp.bvalid && wr_req.bready) begin
                if (bresp_q.size() == 0) begin
                    write_errors++;
                    $display("write response arrived with no accepted write at %0d ns", $time);
                end else begin
                    exp_resp = bresp_q.pop_front();
                    if (wr_rsp.bresp !== exp_resp) begin
                        write_errors++;
                        $display("Fail %0d ns: bresp %0h, expected %0h",
                                 $time, wr_rsp.bresp, exp_resp);
                    end
                end
            end

            // compared on every cycle, so a held item must also stay put
            if (fetch_out.valid) begin
                if (fetch_out.pc !== exp_pc) begin
                    fetch_errors++;
                    $display("Fail %0d ns: item pc %h, expected %h",
                             $time, fetch_out.pc, exp_pc);
                end else begin
                    if (fetch_out.inst !== expected_inst(exp_pc)) begin
                        fetch_errors++;
                        $display("Fail %0d ns: inst %h at pc %h, expected %h",
                                 $time, fetch_out.inst, exp_pc, expected_inst(exp_pc));
                    end
                    if (fetch_out.fault !== (exp_pc >= MEM_BYTES)) begin
                        fetch_errors++;
                        $display("Fail %0d ns: fault %b at pc %h",
                                 $time, fetch_out.fault, exp_pc);
                    end
                end
            end

            consumed = fetch_out.valid && inst_ready;
            if (consumed) begin
                items_consumed <= items_consumed + 1;
            end

            // with run low only the fetch already started may come out
            if (run) begin
                run_low_items = 0;
            end else if (consumed) begin
                run_low_items++;
                if (run_low_items > 1) begin
                    gating_errors++;
                    $display("item delivered after fetching was stopped at %0d ns", $time);
                end
            end

            if (redirect_valid) begin
                exp_pc = redirect_pc;
            end else if (consumed) begin
                exp_pc = exp_pc + 32'd4;
            end
        end
    end

endmodule

// File: dv/ifu_properties.sv
////////////////////////////////////////////////////////////////////////////
// handshake assertions for the fetch unit, bound into ifu_inst_fetch
////////////////////////////////////////////////////////////////////////////

module ifu_properties (
    input logic                clk,
    input logic                rst,
    input logic                pc_taken,
    input ifu_pkg::axi_ar_t    ar,
    input logic                arready,
    input ifu_pkg::axi_r_t     r,
    input logic                rready,
    input ifu_pkg::fetch_out_t fetch_out,
    input logic                inst_ready,
    input logic                redirect_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    int   failures = 0;
    logic read_outstanding;

    // one read may be open between the ar and r handshakes
    always_ff @(posedge clk) begin
        if (rst) begin
            read_outstanding <= 1'b0;
        end else if (ar.arvalid && arready) begin
            read_outstanding <= 1'b1;
        end else if (r.rvalid && rready) begin
            read_outstanding <= 1'b0;
        end
    end

    item_stable: assert property (@(posedge clk) disable iff (rst)
        fetch_out.valid && !inst_ready && !redirect_valid
        |=> fetch_out.valid && $stable(fetch_out))
        else begin
            failures++;
            $error("held fetch item changed before it was taken");
        end

    ar_stable: assert property (@(posedge clk) disable iff (rst)
        ar.arvalid && !arready |=> ar.arvalid && $stable(ar.araddr))
        else begin
            failures++;
            $error("read address dropped or changed before arready");
        end

    rvalid_after_ar: assert property (@(posedge clk) disable iff (rst)
        r.rvalid |-> read_outstanding)
        else begin
            failures++;
            $error("rvalid seen without an accepted read address");
        end

    // first cycle out of reset
    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !ar.arvalid && !r.rvalid && !rready && !pc_taken && !fetch_out.valid)
        else begin
            failures++;
            $error("control output high right after reset");
        end

endmodule

// File: dv/ifu_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the fetch front: loads random words, then runs sequential,
// back-pressured, redirected and gated fetches against the checker
////////////////////////////////////////////////////////////////////////////

module ifu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam ifu_pkg::addr_t RESET_PC = 32'h0;
    localparam int MEM_WORDS    = 64;
    localparam int READ_LATENCY = 2;
    localparam int RAND_WRITES  = 64;
    localparam int NUM_WRITES   = MEM_WORDS + RAND_WRITES;
    localparam int SEQ_ITEMS    = 24;
    localparam int BP_ITEMS     = 24;
    localparam int REDIR_ITEMS  = 40;
    localparam int RESUME_ITEMS = 10;
    localparam int NUM_FETCHES  = SEQ_ITEMS + BP_ITEMS + REDIR_ITEMS + RESUME_ITEMS;
    localparam int WATCHDOG_NS  = (NUM_WRITES + NUM_FETCHES) * 20 * 8;

    logic                 clk;
    logic                 rst;
    logic                 run;
    logic                 redirect_valid;
    ifu_pkg::addr_t       redirect_pc;
    logic                 inst_ready;
    ifu_pkg::axi_wr_req_t wr_req;
    ifu_pkg::fetch_out_t  fetch_out;
    ifu_pkg::axi_wr_rsp_t wr_rsp;
    logic [31:0]          lfsr = 32'h547c;

    ifu_top #(
        .RESET_PC     (RESET_PC),
        .MEM_WORDS    (MEM_WORDS),
        .READ_LATENCY (READ_LATENCY)
    ) UUT (
        .clk            (clk),
        .rst            (rst),
        .run            (run),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .inst_ready     (inst_ready),
        .wr_req         (wr_req),
        .fetch_out      (fetch_out),
        .wr_rsp         (wr_rsp)
    );

    ifu_checker #(
        .RESET_PC  (RESET_PC),
        .MEM_WORDS (MEM_WORDS)
    ) u_checker (
        .clk            (clk),
        .rst            (rst),
        .run            (run),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .inst_ready     (inst_ready),
        .wr_req         (wr_req),
        .fetch_out      (fetch_out),
        .wr_rsp         (wr_rsp)
    );

    bind ifu_inst_fetch ifu_properties u_props (
        .clk            (clk),
        .rst            (rst),
        .pc_taken       (pc_taken),
        .ar             (ar),
        .arready        (arready),
        .r              (r),
        .rready         (rready),
        .fetch_out      (fetch_out),
        .inst_ready     (inst_ready),
        .redirect_valid (redirect_valid)
    );

    // fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    // single write beat, address and data presented together
    task write_word(input ifu_pkg::addr_t addr, input logic [31:0] data,
                    input logic [3:0] strb);
        wr_req.awvalid = 1'b1;
        wr_req.awaddr  = addr;
        wr_req.wvalid  = 1'b1;
        wr_req.wdata   = data;
        wr_req.wstrb   = strb;
        wr_req.bready  = 1'b1;
        do @(posedge clk); while (!wr_rsp.awready);
        #1;
        wr_req.awvalid = 1'b0;
        wr_req.wvalid  = 1'b0;
        do @(posedge clk); while (!wr_rsp.bvalid);
        #1;
    endtask

    // runs until count more items are consumed, with optional random stimulus
    task wait_items(input int count, input bit random_ready, input bit random_redirect);
        int target;
        target = u_checker.items_consumed + count;
        while (u_checker.items_consumed < target) begin
            @(posedge clk);
            #1;
            if (random_ready) begin
                inst_ready = (rand_bits(1) != 0);
            end
            redirect_valid = 1'b0;
            if (random_redirect && rand_bits(4) == 0) begin
                redirect_valid = 1'b1;
                redirect_pc    = rand_bits(7) << 2;
            end
        end
        redirect_valid = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the fetch front stopped making progress");
        $display("tests failed");
        $finish;
    end

    initial begin
        ifu_pkg::addr_t addr;
        logic [31:0]    data;
        logic [3:0]     strb;
        int             total;

        rst            = 1'b1;
        run            = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        inst_ready     = 1'b0;
        wr_req         = '0;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;

        // full-word pass so that no memory word stays unknown
        for (int i = 0; i < MEM_WORDS; i++) begin
            data = rand_bits(32);
            write_word(i * 4, data, 4'hf);
        end
        // random strobes, about one write in eight beyond the memory
        for (int i = 0; i < RAND_WRITES; i++) begin
            if (rand_bits(3) == 0) begin
                addr = MEM_WORDS * 4 + (rand_bits(8) << 2);
            end else begin
                addr = rand_bits($clog2(MEM_WORDS)) << 2;
            end
            data = rand_bits(32);
            strb = 4'(rand_bits(4));
            write_word(addr, data, strb);
        end

        run        = 1'b1;
        inst_ready = 1'b1;
        wait_items(SEQ_ITEMS, 1'b0, 1'b0);
        wait_items(BP_ITEMS, 1'b1, 1'b0);
        wait_items(REDIR_ITEMS, 1'b1, 1'b1);

        inst_ready = 1'b1;
        run        = 1'b0;
        repeat (20) @(posedge clk);
        #1 run = 1'b1;
        wait_items(RESUME_ITEMS, 1'b0, 1'b0);
        repeat (4) @(posedge clk);

        total = u_checker.fetch_errors + u_checker.write_errors + u_checker.gating_errors
              + UUT.u_fetch.u_props.failures;
        $display("errors: fetch %0d, write %0d, run gating %0d, assertions %0d",
                 u_checker.fetch_errors, u_checker.write_errors, u_checker.gating_errors,
                 UUT.u_fetch.u_props.failures);
        if (total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: sources.f
src/ifu_pkg.sv
src/fetch_pc_gen.sv
src/ifu_inst_fetch.sv
src/inst_sram.sv
src/ifu_top.sv
dv/ifu_properties.sv
dv/ifu_checker.sv
dv/ifu_tb.sv

// File: src/fetch_pc_gen.sv
////////////////////////////////////////////////////////////////////////////
// program counter sequencer, steps by one word per accepted fetch and
// takes a redirect target with priority
////////////////////////////////////////////////////////////////////////////

module fetch_pc_gen #(
    parameter ifu_pkg::addr_t RESET_PC = 32'h0
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           run,
    input  logic           redirect_valid,
    input  ifu_pkg::addr_t redirect_pc,
    input  logic           pc_taken,
    output ifu_pkg::addr_t pc,
    output logic           pc_valid
);

    ifu_pkg::addr_t pc_q;
    ifu_pkg::addr_t pc_next;

    // redirect wins over the sequential step
    always_comb begin
        pc_next = pc_q;
        if (redirect_valid) begin
            pc_next = redirect_pc;
        end else if (pc_taken) begin
            pc_next = pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc = pc_q;

    // an address is only offered while the core is running
    assign pc_valid = run;

endmodule

// File: src/ifu_inst_fetch.sv
////////////////////////////////////////////////////////////////////////////
// fetch unit, issues one AXI-lite read per pc and holds the returned word
// until the next stage takes it; redirects flush the fetch in progress
////////////////////////////////////////////////////////////////////////////

module ifu_inst_fetch (
    input  logic                clk,
    input  logic                rst,
    input  ifu_pkg::addr_t      pc,
    input  logic                pc_valid,
    input  logic                redirect_valid,
    input  logic                arready,
    input  ifu_pkg::axi_r_t     r,
    input  logic                inst_ready,
    output logic                pc_taken,
    output ifu_pkg::axi_ar_t    ar,
    output logic                rready,
    output ifu_pkg::fetch_out_t fetch_out
);

    ifu_pkg::fetch_state_e state;
    ifu_pkg::fetch_state_e state_next;

    // pc of the request in flight, also tags the held item
    ifu_pkg::addr_t req_pc;

    // set when the fetch in flight was overtaken by a redirect
    logic drop;
    logic drop_next;

    // held response payload
    ifu_pkg::inst_t hold_inst;
    logic           hold_fault;

    logic r_fire;

    // a redirect in the same cycle moves the pc, so the old one is not taken
    assign pc_taken = (state == ifu_pkg::FETCH_IDLE) && pc_valid && !redirect_valid;

    assign r_fire = rready && r.rvalid;

    always_comb begin
        state_next = state;
        drop_next  = drop;
        case (state)
            ifu_pkg::FETCH_IDLE: begin
                drop_next = 1'b0;
                if (pc_taken) begin
                    state_next = ifu_pkg::FETCH_ADDR;
                end
            end
            ifu_pkg::FETCH_ADDR: begin
                if (redirect_valid) begin
                    drop_next = 1'b1;
                end
                if (arready) begin
                    state_next = ifu_pkg::FETCH_DATA;
                end
            end
            ifu_pkg::FETCH_DATA: begin
                if (redirect_valid) begin
                    drop_next = 1'b1;
                end
                // a dropped response is accepted on the bus and thrown away
                if (r_fire) begin
                    if (drop || redirect_valid) begin
                        state_next = ifu_pkg::FETCH_IDLE;
                    end else begin
                        state_next = ifu_pkg::FETCH_HOLD;
                    end
                end
            end
            ifu_pkg::FETCH_HOLD: begin
                if (redirect_valid || inst_ready) begin
                    state_next = ifu_pkg::FETCH_IDLE;
                end
            end
            default: begin
                state_next = ifu_pkg::FETCH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ifu_pkg::FETCH_IDLE;
            drop  <= 1'b0;
        end else begin
            state <= state_next;
            drop  <= drop_next;
        end
    end

    // request address and response payload
    always_ff @(posedge clk) begin
        if (pc_taken) begin
            req_pc <= pc;
        end
        if (r_fire) begin
            hold_inst  <= r.rdata;
            hold_fault <= (r.rresp == ifu_pkg::SLVERR);
        end
    end

    assign ar.arvalid = (state == ifu_pkg::FETCH_ADDR);
    assign ar.araddr  = req_pc;
    assign rready     = (state == ifu_pkg::FETCH_DATA);

    assign fetch_out.valid = (state == ifu_pkg::FETCH_HOLD);
    assign fetch_out.pc    = req_pc;
    assign fetch_out.inst  = hold_inst;
    assign fetch_out.fault = hold_fault;

endmodule

// File: src/ifu_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared types of the instruction fetch front: addresses, AXI-lite channel
// structs, the fetch output item and the state/response encodings
////////////////////////////////////////////////////////////////////////////

package ifu_pkg;

    // byte address of a fetch or a memory access
    typedef logic [31:0] addr_t;

    // one instruction word
    typedef logic [31:0] inst_t;

    // AXI-lite response codes, only the two used here
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    // fetch unit read master states
    typedef enum logic [1:0] {
        FETCH_IDLE = 2'd0,
        FETCH_ADDR = 2'd1,
        FETCH_DATA = 2'd2,
        FETCH_HOLD = 2'd3
    } fetch_state_e;

    // read address channel, master to slave
    typedef struct packed {
        logic  arvalid;
        addr_t araddr;
    } axi_ar_t;

    // read data channel, slave to master
    typedef struct packed {
        logic      rvalid;
        inst_t     rdata;
        axi_resp_e rresp;
    } axi_r_t;

    // write address, write data and response ready from the loader
    typedef struct packed {
        logic        awvalid;
        addr_t       awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
    } axi_wr_req_t;

    // write channel readies and the write response
    typedef struct packed {
        logic      awready;
        logic      wready;
        logic      bvalid;
        axi_resp_e bresp;
    } axi_wr_rsp_t;

    // item handed to the next pipeline stage
    typedef struct packed {
        logic  valid;
        addr_t pc;
        inst_t inst;
        logic  fault;
    } fetch_out_t;

endpackage

// File: src/ifu_top.sv
////////////////////////////////////////////////////////////////////////////
// fetch front top level, pc sequencer and fetch unit on the read port of
// the instruction SRAM, write port brought out for program loading
////////////////////////////////////////////////////////////////////////////

module ifu_top #(
    parameter ifu_pkg::addr_t RESET_PC     = 32'h0,
    parameter int             MEM_WORDS    = 256,
    parameter int             READ_LATENCY = 2
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 run,
    input  logic                 redirect_valid,
    input  ifu_pkg::addr_t       redirect_pc,
    input  logic                 inst_ready,
    input  ifu_pkg::axi_wr_req_t wr_req,
    output ifu_pkg::fetch_out_t  fetch_out,
    output ifu_pkg::axi_wr_rsp_t wr_rsp
);

    ifu_pkg::addr_t   pc;
    logic             pc_valid;
    logic             pc_taken;

    // read channel between fetch unit and memory
    ifu_pkg::axi_ar_t ar;
    logic             arready;
    ifu_pkg::axi_r_t  r;
    logic             rready;

    fetch_pc_gen #(
        .RESET_PC (RESET_PC)
    ) u_pc_gen (
        .clk            (clk),
        .rst            (rst),
        .run            (run),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .pc_taken       (pc_taken),
        .pc             (pc),
        .pc_valid       (pc_valid)
    );

    ifu_inst_fetch u_fetch (
        .clk            (clk),
        .rst            (rst),
        .pc             (pc),
        .pc_valid       (pc_valid),
        .redirect_valid (redirect_valid),
        .arready        (arready),
        .r              (r),
        .inst_ready     (inst_ready),
        .pc_taken       (pc_taken),
        .ar             (ar),
        .rready         (rready),
        .fetch_out      (fetch_out)
    );

    inst_sram #(
        .MEM_WORDS    (MEM_WORDS),
        .READ_LATENCY (READ_LATENCY)
    ) u_sram (
        .clk     (clk),
        .rst     (rst),
        .ar      (ar),
        .rready  (rready),
        .wr_req  (wr_req),
        .arready (arready),
        .r       (r),
        .wr_rsp  (wr_rsp)
    );

endmodule

// File: src/inst_sram.sv
////////////////////////////////////////////////////////////////////////////
// word-addressed instruction memory behind an AXI-lite slave port, read
// data after a fixed latency, byte-strobed single-beat writes
////////////////////////////////////////////////////////////////////////////

module inst_sram #(
    parameter int MEM_WORDS    = 256,
    parameter int READ_LATENCY = 2
) (
    input  logic                 clk,
    input  logic                 rst,
    input  ifu_pkg::axi_ar_t     ar,
    input  logic                 rready,
    input  ifu_pkg::axi_wr_req_t wr_req,
    output logic                 arready,
    output ifu_pkg::axi_r_t      r,
    output ifu_pkg::axi_wr_rsp_t wr_rsp
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int CNT_W = $clog2(READ_LATENCY + 1);
    localparam ifu_pkg::addr_t MEM_BYTES = MEM_WORDS * 4;

    logic [31:0] mem [MEM_WORDS];

    // read side
    logic               rd_busy;
    logic [CNT_W-1:0]   rd_cnt;
    ifu_pkg::inst_t     rd_data;
    ifu_pkg::axi_resp_e rd_resp;
    logic               ar_fire;
    logic               rd_in_range;
    logic [IDX_W-1:0]   rd_idx;

    // write side
    logic               wr_fire;
    logic               wr_in_range;
    logic [IDX_W-1:0]   wr_idx;
    logic               bvalid;
    ifu_pkg::axi_resp_e bresp;

    assign rd_in_range = (ar.araddr < MEM_BYTES);
    assign rd_idx      = ar.araddr[IDX_W+1:2];
    assign arready     = !rd_busy;
    assign ar_fire     = ar.arvalid && arready;

    // rvalid shows once the latency counter has run down
    assign r.rvalid = rd_busy && (rd_cnt == '0);
    assign r.rdata  = rd_data;
    assign r.rresp  = rd_resp;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_busy <= 1'b0;
            rd_cnt  <= '0;
        end else if (ar_fire) begin
            rd_busy <= 1'b1;
            rd_cnt  <= CNT_W'(READ_LATENCY - 1);
        end else if (rd_busy) begin
            if (rd_cnt != '0) begin
                rd_cnt <= rd_cnt - 1'b1;
            end else if (rready) begin
                rd_busy <= 1'b0;
            end
        end
    end

    // data is captured at address time and presented after the delay
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            if (rd_in_range) begin
                rd_data <= mem[rd_idx];
                rd_resp <= ifu_pkg::OKAY;
            end else begin
                rd_data <= '0;
                rd_resp <= ifu_pkg::SLVERR;
            end
        end
    end

    assign wr_in_range = (wr_req.awaddr < MEM_BYTES);
    assign wr_idx      = wr_req.awaddr[IDX_W+1:2];

    // address and data are taken together, never while a response waits
    assign wr_fire = wr_req.awvalid && wr_req.wvalid && !bvalid;

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            bresp  <= ifu_pkg::OKAY;
        end else if (wr_fire) begin
            bvalid <= 1'b1;
            bresp  <= wr_in_range ? ifu_pkg::OKAY : ifu_pkg::SLVERR;
        end else if (bvalid && wr_req.bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire && wr_in_range) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_req.wstrb[b]) begin
                    mem[wr_idx][8*b +: 8] <= wr_req.wdata[8*b +: 8];
                end
            end
        end
    end

    assign wr_rsp.awready = wr_fire;
    assign wr_rsp.wready  = wr_fire;
    assign wr_rsp.bvalid  = bvalid;
    assign wr_rsp.bresp   = bresp;

endmodule
